//--- fifo_pkg.sv
`default_nettype none

package fifo_pkg;

  // **************************************************
  // sizes and flag thresholds
  // **************************************************
  localparam int DATA_W       = 8;
  localparam int FIFO_DEPTH   = 16;
  localparam int ADDR_W       = $clog2(FIFO_DEPTH);
  localparam int AFULL_LEVEL  = 14;
  localparam int AEMPTY_LEVEL = 2;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  // top bit tells the two wraps apart
  typedef logic [ADDR_W:0]   ptr_t;

  typedef struct packed {
    logic full;
    logic afull;
  } wr_status_t;

  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_status_t;

  // **************************************************
  // gray code helpers
  // **************************************************
  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[ADDR_W] = gray[ADDR_W];
    for (int i = ADDR_W - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

//--- dual_port_ram.sv
`default_nettype none

module dual_port_ram (
  input  wire logic            wr_clk,
  input  wire logic            wr_en,
  input  wire fifo_pkg::addr_t wr_addr,
  input  wire fifo_pkg::data_t wr_data,
  input  wire logic            rd_clk,
  input  wire logic            rd_rst_n,
  input  wire logic            rd_en,
  input  wire fifo_pkg::addr_t rd_addr,
  output fifo_pkg::data_t      rd_data
);

  import fifo_pkg::*;

  data_t mem [FIFO_DEPTH];

  // **************************************************
  // write port
  // **************************************************
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // **************************************************
  // registered read port
  // **************************************************
  // word is held until the next accepted read
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- gray_ptr_sync.sv
`default_nettype none

module gray_ptr_sync (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire fifo_pkg::ptr_t gray_in,
  output fifo_pkg::ptr_t      gray_out
);

  import fifo_pkg::*;

  ptr_t meta_q;
  ptr_t sync_q;

  // only one bit moves per source edge, so a plain
  // two-flop chain lands on either the old or new pointer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= gray_in;
      sync_q <= meta_q;
    end
  end

  assign gray_out = sync_q;

endmodule

`default_nettype wire

//--- fifo_wr_ctrl.sv
`default_nettype none

module fifo_wr_ctrl (
  input  wire logic           wr_clk,
  input  wire logic           wr_rst_n,
  input  wire logic           wr_en,
  input  wire fifo_pkg::ptr_t rd_gray_sync,
  output logic                wr_rst_n_sync,
  output logic                wr_push,
  output fifo_pkg::addr_t     wr_addr,
  output fifo_pkg::ptr_t      wr_gray,
  output fifo_pkg::wr_status_t wr_status
);

  import fifo_pkg::*;

  logic [1:0] rst_sync_q;

  ptr_t       wr_bin;
  ptr_t       wr_bin_next;
  ptr_t       wr_gray_next;
  ptr_t       rd_bin_sync;
  ptr_t       wr_used_next;
  wr_status_t status_next;

  // **************************************************
  // reset release
  // **************************************************
  // assert at once, release after two wr_clk edges
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign wr_rst_n_sync = rst_sync_q[1];

  // **************************************************
  // write pointer
  // **************************************************
  assign wr_push = wr_en & ~wr_status.full;

  always_comb begin
    wr_bin_next  = wr_bin + {{ADDR_W{1'b0}}, wr_push};
    wr_gray_next = bin2gray(wr_bin_next);
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n_sync) begin
    if (!wr_rst_n_sync) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_next;
      wr_gray <= wr_gray_next;
    end
  end

  assign wr_addr = wr_bin[ADDR_W-1:0];

  // **************************************************
  // full and almost full
  // **************************************************
  // the synced read pointer lags, so occupancy only overestimates
  always_comb begin
    rd_bin_sync       = gray2bin(rd_gray_sync);
    wr_used_next      = wr_bin_next - rd_bin_sync;
    status_next.full  = (wr_used_next == ptr_t'(FIFO_DEPTH));
    status_next.afull = (wr_used_next >= ptr_t'(AFULL_LEVEL));
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n_sync) begin
    if (!wr_rst_n_sync) begin
      wr_status <= '{full: 1'b0, afull: 1'b0};
    end else begin
      wr_status <= status_next;
    end
  end

endmodule

`default_nettype wire

//--- fifo_rd_ctrl.sv
`default_nettype none

module fifo_rd_ctrl (
  input  wire logic           rd_clk,
  input  wire logic           wr_rst_n,
  input  wire logic           rd_en,
  input  wire fifo_pkg::ptr_t wr_gray_sync,
  output logic                rd_rst_n_sync,
  output logic                rd_pop,
  output fifo_pkg::addr_t     rd_addr,
  output fifo_pkg::ptr_t      rd_gray,
  output fifo_pkg::rd_status_t rd_status
);

  import fifo_pkg::*;

  logic [1:0] rst_sync_q;

  ptr_t       rd_bin;
  ptr_t       rd_bin_next;
  ptr_t       rd_gray_next;
  ptr_t       wr_bin_sync;
  ptr_t       rd_used_next;
  rd_status_t status_next;

  // **************************************************
  // reset release
  // **************************************************
  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign rd_rst_n_sync = rst_sync_q[1];

  // **************************************************
  // read pointer
  // **************************************************
  assign rd_pop = rd_en & ~rd_status.empty;

  always_comb begin
    rd_bin_next  = rd_bin + {{ADDR_W{1'b0}}, rd_pop};
    rd_gray_next = bin2gray(rd_bin_next);
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n_sync) begin
    if (!rd_rst_n_sync) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_next;
      rd_gray <= rd_gray_next;
    end
  end

  assign rd_addr = rd_bin[ADDR_W-1:0];

  // **************************************************
  // empty and almost empty
  // **************************************************
  // stale write pointer can only make the fifo look emptier
  always_comb begin
    wr_bin_sync        = gray2bin(wr_gray_sync);
    rd_used_next       = wr_bin_sync - rd_bin_next;
    status_next.empty  = (rd_gray_next == wr_gray_sync);
    status_next.aempty = (rd_used_next <= ptr_t'(AEMPTY_LEVEL));
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n_sync) begin
    if (!rd_rst_n_sync) begin
      rd_status <= '{empty: 1'b1, aempty: 1'b1};
    end else begin
      rd_status <= status_next;
    end
  end

endmodule

`default_nettype wire

//--- async_fifo.sv
`default_nettype none

module async_fifo (
  input  wire logic             wr_clk,
  input  wire logic             wr_rst_n,
  input  wire logic             wr_en,
  input  wire fifo_pkg::data_t  wr_data,
  output fifo_pkg::wr_status_t  wr_status,
  input  wire logic             rd_clk,
  input  wire logic             rd_en,
  output fifo_pkg::data_t       rd_data,
  output fifo_pkg::rd_status_t  rd_status
);

  import fifo_pkg::*;

  logic  wr_rst_n_sync;
  logic  rd_rst_n_sync;
  logic  wr_push;
  logic  rd_pop;
  addr_t wr_addr;
  addr_t rd_addr;
  ptr_t  wr_gray;
  ptr_t  rd_gray;
  ptr_t  wr_gray_sync;
  ptr_t  rd_gray_sync;

  // **************************************************
  // write domain
  // **************************************************
  fifo_wr_ctrl i_wr_ctrl (
    .wr_clk        (wr_clk),
    .wr_rst_n      (wr_rst_n),
    .wr_en         (wr_en),
    .rd_gray_sync  (rd_gray_sync),
    .wr_rst_n_sync (wr_rst_n_sync),
    .wr_push       (wr_push),
    .wr_addr       (wr_addr),
    .wr_gray       (wr_gray),
    .wr_status     (wr_status)
  );

  gray_ptr_sync i_rd2wr (
    .clk      (wr_clk),
    .rst_n    (wr_rst_n_sync),
    .gray_in  (rd_gray),
    .gray_out (rd_gray_sync)
  );

  // **************************************************
  // read domain
  // **************************************************
  fifo_rd_ctrl i_rd_ctrl (
    .rd_clk        (rd_clk),
    .wr_rst_n      (wr_rst_n),
    .rd_en         (rd_en),
    .wr_gray_sync  (wr_gray_sync),
    .rd_rst_n_sync (rd_rst_n_sync),
    .rd_pop        (rd_pop),
    .rd_addr       (rd_addr),
    .rd_gray       (rd_gray),
    .rd_status     (rd_status)
  );

  gray_ptr_sync i_wr2rd (
    .clk      (rd_clk),
    .rst_n    (rd_rst_n_sync),
    .gray_in  (wr_gray),
    .gray_out (wr_gray_sync)
  );

  // storage shared by both domains
  dual_port_ram i_ram (
    .wr_clk   (wr_clk),
    .wr_en    (wr_push),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n_sync),
    .rd_en    (rd_pop),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

`default_nettype wire

//--- async_fifo_assertions.sv
`default_nettype none

module async_fifo_assertions (
  input wire logic                 wr_clk,
  input wire logic                 rd_clk,
  input wire logic                 wr_rst_n_sync,
  input wire logic                 rd_rst_n_sync,
  input wire fifo_pkg::wr_status_t wr_status,
  input wire fifo_pkg::rd_status_t rd_status,
  input wire fifo_pkg::ptr_t       wr_gray,
  input wire fifo_pkg::ptr_t       rd_gray
);

  // flags from the first update after each domain leaves reset
  wr_reset_flags: assert property (@(posedge wr_clk)
    $rose(wr_rst_n_sync) |=> !wr_status.full && !wr_status.afull)
    else $error("full or afull set as the write domain left reset");

  rd_reset_flags: assert property (@(posedge rd_clk)
    $rose(rd_rst_n_sync) |=> rd_status.empty && rd_status.aempty)
    else $error("empty or aempty clear as the read domain left reset");

  full_has_afull: assert property (@(posedge wr_clk) disable iff (!wr_rst_n_sync)
    wr_status.full |-> wr_status.afull)
    else $error("full set without afull");

  empty_has_aempty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n_sync)
    rd_status.empty |-> rd_status.aempty)
    else $error("empty set without aempty");

  // gray pointers may move by one bit per edge at most
  wr_gray_step: assert property (@(posedge wr_clk) disable iff (!wr_rst_n_sync)
    $countones(wr_gray ^ $past(wr_gray)) <= 1)
    else $error("wr_gray changed in more than one bit");

  rd_gray_step: assert property (@(posedge rd_clk) disable iff (!rd_rst_n_sync)
    $countones(rd_gray ^ $past(rd_gray)) <= 1)
    else $error("rd_gray changed in more than one bit");

endmodule

bind async_fifo async_fifo_assertions i_assertions (
  .wr_clk        (wr_clk),
  .rd_clk        (rd_clk),
  .wr_rst_n_sync (wr_rst_n_sync),
  .rd_rst_n_sync (rd_rst_n_sync),
  .wr_status     (wr_status),
  .rd_status     (rd_status),
  .wr_gray       (wr_gray),
  .rd_gray       (rd_gray)
);

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic rd_clk,
  output logic wr_clk
);

  localparam int RD_HALF = 10;
  localparam int WR_HALF = 7;

  // rising edges of the two clocks never coincide
  initial begin
    rd_clk = 1'b0;
    forever #(RD_HALF) rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #(WR_HALF) wr_clk = ~wr_clk;
  end

endmodule

`default_nettype wire

//--- tb_async_fifo.sv
`default_nettype none

module tb_async_fifo;

  import fifo_pkg::*;

  localparam logic [31:0] SEED = 32'he02c45e8;
  // test lengths in cycles, summed for the watchdog
  localparam int LEN_RESET  = 20;
  localparam int LEN_ORDER  = 300;
  localparam int LEN_LIMITS = 120;
  localparam int LEN_FLAGS  = 200;
  localparam int WATCHDOG   = (LEN_RESET + LEN_ORDER + LEN_LIMITS + LEN_FLAGS) * 14 * 4;
  localparam int FLAG_TARGETS [6] = '{2, 3, 14, 13, 16, 0};

  logic        wr_clk;
  logic        rd_clk;
  logic        wr_rst_n;
  logic        wr_en;
  logic        rd_en;
  data_t       wr_data;
  data_t       rd_data;
  data_t       last_word = '0;
  wr_status_t  wr_status;
  rd_status_t  rd_status;
  data_t       model_q [$];
  logic [31:0] wr_rnd = SEED;
  logic [31:0] rd_rnd = {SEED[15:0], SEED[31:16]};
  int          error_count = 0;
  int          errors_at_start = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;

  tb_clock_gen i_clk_gen (.*);

  async_fifo i_dut (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic compare(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
    if (got !== expected) begin
      $display("mismatch %s: got %h, expected %h", name, got, expected);
      error_count++;
    end
  endtask

  task automatic report_test(input string name);
    int errs;
    errs = error_count - errors_at_start;
    if (errs == 0) tests_passed++;
    else tests_failed++;
    $display("%s: %s, %0d errors", name, errs == 0 ? "passed" : "failed", errs);
    errors_at_start = error_count;
  endtask

  // both enables low, then wait for the pointers to cross
  task automatic idle_both();
    @(negedge wr_clk);
    wr_en = 1'b0;
    @(negedge rd_clk);
    rd_en = 1'b0;
    repeat (8) @(negedge rd_clk);
  endtask

  task automatic check_flags();
    int cnt;
    cnt = model_q.size();
    compare("rd_status.empty", 32'(rd_status.empty), 32'(cnt == 0));
    compare("rd_status.aempty", 32'(rd_status.aempty), 32'(cnt <= AEMPTY_LEVEL));
    compare("wr_status.full", 32'(wr_status.full), 32'(cnt == FIFO_DEPTH));
    compare("wr_status.afull", 32'(wr_status.afull), 32'(cnt >= AFULL_LEVEL));
  endtask

  // targets past full or below zero give extra refused accesses
  task automatic move_count(input int target);
    int diff;
    diff = target - model_q.size();
    repeat (diff > 0 ? diff : 0) begin
      @(negedge wr_clk);
      wr_rnd  = xorshift(wr_rnd);
      wr_en   = 1'b1;
      wr_data = wr_rnd[7:0];
    end
    repeat (diff < 0 ? -diff : 0) begin
      @(negedge rd_clk);
      rd_en = 1'b1;
    end
    idle_both();
  endtask

  // **************************************************
  // reference model
  // **************************************************
  initial begin
    forever begin
      @(posedge wr_clk);
      if (wr_rst_n && wr_en && !wr_status.full) begin
        if (model_q.size() >= FIFO_DEPTH) begin
          $display("write accepted with %0d words already in the model", model_q.size());
          error_count++;
        end
        model_q.push_back(wr_data);
      end
    end
  end

  // rd_data is checked half a cycle after the edge that loads it
  initial begin
    data_t exp_word;
    forever begin
      @(posedge rd_clk);
      if (wr_rst_n && rd_en && !rd_status.empty) begin
        if (model_q.size() == 0) begin
          $display("read accepted while the model holds no words");
          error_count++;
        end else begin
          exp_word  = model_q.pop_front();
          last_word = exp_word;
          @(negedge rd_clk);
          compare("rd_data", 32'(rd_data), 32'(exp_word));
        end
      end
    end
  end

  initial begin
    #(WATCHDOG);
    $display("watchdog expired, the tests did not finish in %0d time units", WATCHDOG);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // **************************************************
  // tests
  // **************************************************
  initial begin
    wr_rst_n = 1'b0;
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    wr_data  = '0;

    repeat (8) @(posedge rd_clk);
    @(negedge rd_clk);
    wr_rst_n = 1'b1;
    repeat (4) @(negedge rd_clk);
    check_flags();
    compare("rd_data", 32'(rd_data), 32'h0);
    report_test("reset state");

    fork
      repeat (LEN_ORDER - 20) begin
        @(negedge wr_clk);
        wr_rnd  = xorshift(wr_rnd);
        wr_en   = wr_rnd[0];
        wr_data = wr_rnd[15:8];
      end
      repeat (LEN_ORDER - 20) begin
        @(negedge rd_clk);
        rd_rnd = xorshift(rd_rnd);
        rd_en  = rd_rnd[0];
      end
    join
    idle_both();
    report_test("ordering");

    move_count(FIFO_DEPTH + 4);
    compare("model count", 32'(model_q.size()), 32'(FIFO_DEPTH));
    check_flags();
    report_test("overflow");

    move_count(-4);
    compare("model count", 32'(model_q.size()), 32'h0);
    compare("rd_data", 32'(rd_data), 32'(last_word));
    check_flags();
    report_test("underflow");

    for (int i = 0; i < 6; i++) begin
      move_count(FLAG_TARGETS[i]);
      check_flags();
    end
    report_test("settled flags");

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
fifo_pkg.sv
dual_port_ram.sv
gray_ptr_sync.sv
fifo_wr_ctrl.sv
fifo_rd_ctrl.sv
async_fifo.sv
async_fifo_assertions.sv
tb_clock_gen.sv
tb_async_fifo.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert --top-module tb_async_fifo \
    -f filelist.f -o tb_async_fifo_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_async_fifo_sim > "$log" 2>&1; then
  cat "$log"
  echo "simulation exited with an error"
  exit 1
fi
cat "$log"

if grep -q "TEST RESULT: FAIL" "$log"; then
  exit 1
fi
exit 0
